//--- icache_pkg.sv
package icache_pkg;

    // geometry of the two-way cache
    localparam int num_sets = 64;
    localparam int num_ways = 2;

    // fetch address fields
    localparam int index_w  = 6;
    localparam int tag_w    = 23;
    localparam int offset_w = 3;

    // payload widths
    localparam int line_w = 64;
    localparam int word_w = 32;

    // memory side works on whole lines, tag and index only
    localparam int line_addr_w = tag_w + index_w;

    // processor fetch address, tag in the top bits
    typedef struct packed {
        logic [tag_w-1:0]    tag;
        logic [index_w-1:0]  index;
        logic [offset_w-1:0] offset;
    } fetch_addr_t;

    // tag array entry
    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
    } vtag_t;

    // one cache line, word 1 in the upper half
    // indexed directly by offset bit 2
    typedef struct packed {
        logic [line_w/word_w-1:0][word_w-1:0] words;
    } line_t;

    // controller FSM
    typedef enum logic [1:0] {
        idle,
        lookup,
        miss,
        replace
    } ic_state_t;

endpackage

//--- icache_sram.sv
module icache_sram #(
    parameter type word_t = icache_pkg::line_t
) (
    input  logic                            clk,
    input  logic                            en,
    input  logic [icache_pkg::num_ways-1:0] we,
    input  logic [icache_pkg::index_w-1:0]  addr,
    input  word_t                           wdata,
    output word_t                           rdata [icache_pkg::num_ways]
);

    // one entry per way per set
    word_t mem [icache_pkg::num_sets][icache_pkg::num_ways];

    // single port, registered read
    // a written way reads back its old contents in the same cycle
    always_ff @(posedge clk) begin
        if (en) begin
            for (int w = 0; w < icache_pkg::num_ways; w++) begin
                if (we[w]) begin
                    mem[addr][w] <= wdata;
                end
                rdata[w] <= mem[addr][w];
            end
        end
    end

endmodule

//--- icache_ctrl.sv
module icache_ctrl (
    input  logic                               clk,
    input  logic                               rst,
    // processor side
    input  logic                               req_valid,
    input  icache_pkg::fetch_addr_t            req_addr,
    output logic                               addr_ok,
    output logic                               data_ok,
    output logic [icache_pkg::word_w-1:0]      rdata,
    // memory side
    output logic                               rd_req,
    output logic [icache_pkg::line_addr_w-1:0] rd_line_addr,
    input  logic                               ret_valid,
    input  icache_pkg::line_t                  ret_data,
    // tag array
    output logic                               tag_en,
    output logic [icache_pkg::num_ways-1:0]    tag_we,
    output logic [icache_pkg::index_w-1:0]     tag_addr,
    output icache_pkg::vtag_t                  tag_wdata,
    input  icache_pkg::vtag_t                  tag_rdata [icache_pkg::num_ways],
    // data array
    output logic                               data_en,
    output logic [icache_pkg::num_ways-1:0]    data_we,
    output logic [icache_pkg::index_w-1:0]     data_addr,
    output icache_pkg::line_t                  data_wdata,
    input  icache_pkg::line_t                  data_rdata [icache_pkg::num_ways]
);

    icache_pkg::ic_state_t state;
    icache_pkg::ic_state_t next_state;

    icache_pkg::fetch_addr_t req_buf;
    icache_pkg::line_t       miss_buf;
    icache_pkg::line_t       hit_line;

    logic [icache_pkg::num_sets-1:0] lru;
    logic [icache_pkg::num_ways-1:0] way_hit;
    logic [icache_pkg::num_ways-1:0] fill_we;
    logic [icache_pkg::index_w-1:0]  sweep_cnt;

    logic sweep_busy;
    logic accept;
    logic cache_hit;
    logic hit_way;
    logic victim;
    logic next_victim;

    assign accept = req_valid && addr_ok;

    // tag array clear after reset, one set per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            sweep_busy <= 1'b1;
            sweep_cnt  <= '0;
        end else if (sweep_busy) begin
            sweep_cnt <= sweep_cnt + 1'b1;
            if (&sweep_cnt) begin
                sweep_busy <= 1'b0;
            end
        end
    end

    // request buffer
    always_ff @(posedge clk) begin
        if (accept) begin
            req_buf <= req_addr;
        end
    end

    // miss buffer holds the returned line until replace
    always_ff @(posedge clk) begin
        if (state == icache_pkg::miss && ret_valid) begin
            miss_buf <= ret_data;
        end
    end

    // tag compare against the buffered request
    always_comb begin
        for (int w = 0; w < icache_pkg::num_ways; w++) begin
            way_hit[w] = tag_rdata[w].valid && (tag_rdata[w].tag == req_buf.tag);
        end
    end

    assign cache_hit = |way_hit;
    assign hit_way   = way_hit[1];
    assign hit_line  = hit_way ? data_rdata[1] : data_rdata[0];

    // invalid ways fill first, way 0 before way 1
    always_comb begin
        if (!tag_rdata[0].valid) begin
            next_victim = 1'b0;
        end else if (!tag_rdata[1].valid) begin
            next_victim = 1'b1;
        end else begin
            next_victim = lru[req_buf.index];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            victim <= 1'b0;
        end else if (state == icache_pkg::lookup && !cache_hit) begin
            victim <= next_victim;
        end
    end

    // lru bit names the way to replace next
    always_ff @(posedge clk) begin
        if (rst) begin
            lru <= '0;
        end else if (state == icache_pkg::lookup && cache_hit) begin
            lru[req_buf.index] <= ~hit_way;
        end else if (state == icache_pkg::replace) begin
            lru[req_buf.index] <= ~victim;
        end
    end

    // next state
    always_comb begin
        next_state = state;
        unique case (state)
            icache_pkg::idle: begin
                if (accept) begin
                    next_state = icache_pkg::lookup;
                end
            end
            icache_pkg::lookup: begin
                if (!cache_hit) begin
                    next_state = icache_pkg::miss;
                end else if (!accept) begin
                    next_state = icache_pkg::idle;
                end
            end
            icache_pkg::miss: begin
                if (ret_valid) begin
                    next_state = icache_pkg::replace;
                end
            end
            icache_pkg::replace: begin
                next_state = icache_pkg::idle;
            end
            default: begin
                next_state = icache_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= icache_pkg::idle;
        end else begin
            state <= next_state;
        end
    end

    // processor handshake
    assign addr_ok = !sweep_busy
        && (state == icache_pkg::idle || (state == icache_pkg::lookup && cache_hit));
    assign data_ok = (state == icache_pkg::lookup && cache_hit)
        || state == icache_pkg::replace;
    assign rdata = (state == icache_pkg::replace) ? miss_buf.words[req_buf.offset[2]]
                                                  : hit_line.words[req_buf.offset[2]];

    // line read toward memory
    assign rd_req       = (state == icache_pkg::miss);
    assign rd_line_addr = {req_buf.tag, req_buf.index};

    // fill goes to the latched victim only
    always_comb begin
        fill_we = '0;
        if (state == icache_pkg::replace) begin
            fill_we[victim] = 1'b1;
        end
    end

    // arrays read at the incoming index on acceptance, write on replace
    assign tag_en   = sweep_busy || accept || state == icache_pkg::replace;
    assign tag_we   = sweep_busy ? '1 : fill_we;
    assign tag_addr = sweep_busy ? sweep_cnt
                    : (state == icache_pkg::replace) ? req_buf.index : req_addr.index;

    always_comb begin
        tag_wdata.valid = !sweep_busy;
        tag_wdata.tag   = sweep_busy ? '0 : req_buf.tag;
    end

    assign data_en    = accept || state == icache_pkg::replace;
    assign data_we    = fill_we;
    assign data_addr  = (state == icache_pkg::replace) ? req_buf.index : req_addr.index;
    assign data_wdata = miss_buf;

endmodule

//--- icache_top.sv
module icache_top (
    input  logic                               clk,
    input  logic                               rst,
    // processor side
    input  logic                               req_valid,
    input  icache_pkg::fetch_addr_t            req_addr,
    output logic                               addr_ok,
    output logic                               data_ok,
    output logic [icache_pkg::word_w-1:0]      rdata,
    // memory side
    output logic                               rd_req,
    output logic [icache_pkg::line_addr_w-1:0] rd_line_addr,
    input  logic                               ret_valid,
    input  icache_pkg::line_t                  ret_data
);

    // tag array wiring
    logic                            tag_en;
    logic [icache_pkg::num_ways-1:0] tag_we;
    logic [icache_pkg::index_w-1:0]  tag_addr;
    icache_pkg::vtag_t               tag_wdata;
    icache_pkg::vtag_t               tag_rdata [icache_pkg::num_ways];

    // data array wiring
    logic                            data_en;
    logic [icache_pkg::num_ways-1:0] data_we;
    logic [icache_pkg::index_w-1:0]  data_addr;
    icache_pkg::line_t               data_wdata;
    icache_pkg::line_t               data_rdata [icache_pkg::num_ways];

    icache_ctrl i_ctrl (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req_addr     (req_addr),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .rdata        (rdata),
        .rd_req       (rd_req),
        .rd_line_addr (rd_line_addr),
        .ret_valid    (ret_valid),
        .ret_data     (ret_data),
        .tag_en       (tag_en),
        .tag_we       (tag_we),
        .tag_addr     (tag_addr),
        .tag_wdata    (tag_wdata),
        .tag_rdata    (tag_rdata),
        .data_en      (data_en),
        .data_we      (data_we),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_rdata   (data_rdata)
    );

    icache_sram #(
        .word_t (icache_pkg::vtag_t)
    ) i_tag_array (
        .clk   (clk),
        .en    (tag_en),
        .we    (tag_we),
        .addr  (tag_addr),
        .wdata (tag_wdata),
        .rdata (tag_rdata)
    );

    icache_sram #(
        .word_t (icache_pkg::line_t)
    ) i_data_array (
        .clk   (clk),
        .en    (data_en),
        .we    (data_we),
        .addr  (data_addr),
        .wdata (data_wdata),
        .rdata (data_rdata)
    );

endmodule

//--- icache_mem_model.sv
module icache_mem_model (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               rd_req,
    input  logic [icache_pkg::line_addr_w-1:0] rd_line_addr,
    output logic                               ret_valid,
    output icache_pkg::line_t                  ret_data
);
    timeunit 1ns;
    timeprecision 1ps;

    logic busy;
    int   delay;

    // one line read at a time, answered after a random delay
    always @(posedge clk) begin
        if (rst) begin
            ret_valid <= 1'b0;
            ret_data  <= '0;
            busy      <= 1'b0;
        end else begin
            ret_valid <= 1'b0;
            if (rd_req && !busy && !ret_valid) begin
                busy  <= 1'b1;
                delay <= $urandom_range(8, 1);
            end else if (busy) begin
                delay <= delay - 1;
                if (delay == 1) begin
                    busy      <= 1'b0;
                    ret_valid <= 1'b1;
                    // each word is its byte address mixed with a constant
                    ret_data.words[0] <= {rd_line_addr, 3'b000} ^ 32'h9e37_79b9;
                    ret_data.words[1] <= {rd_line_addr, 3'b100} ^ 32'h9e37_79b9;
                end
            end
        end
    end

endmodule

//--- icache_assert.sv
module icache_assert (
    input logic                               clk,
    input logic                               rst,
    input logic                               req_valid,
    input logic                               addr_ok,
    input logic                               data_ok,
    input logic                               rd_req,
    input logic                               ret_valid,
    input logic [icache_pkg::line_addr_w-1:0] rd_line_addr,
    input icache_pkg::ic_state_t              state
);
    timeunit 1ns;
    timeprecision 1ps;

    // line read held until memory answers
    read_held: assert property (@(posedge clk) disable iff (rst)
        rd_req && !ret_valid |=> rd_req && $stable(rd_line_addr))
        else $error("rd_req dropped or rd_line_addr changed before ret_valid");

    no_accept_during_read: assert property (@(posedge clk) disable iff (rst)
        !(rd_req && addr_ok))
        else $error("addr_ok high while a line read is pending");

    // data one cycle after an accepted hit or a returned line
    data_source: assert property (@(posedge clk) disable iff (rst)
        data_ok |-> (state == icache_pkg::lookup && $past(req_valid && addr_ok))
            || (state == icache_pkg::replace && $past(ret_valid)))
        else $error("data_ok without an accepted request or a returned line");

    // memory answers only a pending read
    return_needs_read: assert property (@(posedge clk) disable iff (rst)
        ret_valid |-> rd_req)
        else $error("ret_valid arrived with no rd_req pending");

endmodule

bind icache_ctrl icache_assert i_assert (.*);

//--- icache_tb.sv
module icache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_tests     = 5;
    localparam int max_fetches = 16;
    // worst fetch cost per test, then reset and the tag sweep
    localparam int cycle_limit = n_tests * max_fetches * (8 + 4) + 3 + icache_pkg::num_sets;

    logic                               clk = 1'b0;
    logic                               rst;
    logic                               req_valid;
    icache_pkg::fetch_addr_t            req_addr;
    logic                               addr_ok;
    logic                               data_ok;
    logic [icache_pkg::word_w-1:0]      rdata;
    logic                               rd_req;
    logic [icache_pkg::line_addr_w-1:0] rd_line_addr;
    logic                               ret_valid;
    icache_pkg::line_t                  ret_data;

    int cycle_cnt = 0;
    int errors = 0;
    int checks = 0;
    int failed_tests = 0;
    int errors_at_start = 0;
    int misses_seen;
    int first_ok;
    int last_ok;
    logic [31:0] fetch_q[$];

    // expected cache contents
    // lru bit names the next victim
    logic                         model_valid [icache_pkg::num_sets][icache_pkg::num_ways];
    logic [icache_pkg::tag_w-1:0] model_tag [icache_pkg::num_sets][icache_pkg::num_ways];
    logic                         model_lru [icache_pkg::num_sets];

    icache_top i_dut (.*);
    icache_mem_model i_mem (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles, a fetch never completed", cycle_limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic logic [31:0] make_addr(input int tag, input int index, input int word);
        icache_pkg::fetch_addr_t fa;
        fa.tag    = tag[icache_pkg::tag_w-1:0];
        fa.index  = index[icache_pkg::index_w-1:0];
        fa.offset = {word[0], 2'b00};
        return fa;
    endfunction

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ 32'h9e37_79b9;
    endfunction

    // predicts hit or miss, then updates the model
    function automatic bit model_access(input icache_pkg::fetch_addr_t fa);
        int victim;
        for (int w = 0; w < icache_pkg::num_ways; w++) begin
            if (model_valid[fa.index][w] && model_tag[fa.index][w] == fa.tag) begin
                model_lru[fa.index] = (w == 0);
                return 1'b1;
            end
        end
        victim = !model_valid[fa.index][0] ? 0
               : !model_valid[fa.index][1] ? 1 : model_lru[fa.index];
        model_valid[fa.index][victim] = 1'b1;
        model_tag[fa.index][victim]   = fa.tag;
        model_lru[fa.index]           = (victim == 0);
        return 1'b0;
    endfunction

    task automatic check_that(input bit ok, input string what);
        checks++;
        assert (ok) else begin
            $display("[FAIL] %0t: %s", $time, what);
            errors++;
        end
    endtask

    // streams fetch_q through the DUT and checks every returned word
    task automatic run_fetches();
        logic [31:0] exp_addr[$];
        bit          exp_hit[$];
        int          acc_cyc[$];
        int          sent;
        bit          saw_req;
        sent        = 0;
        saw_req     = 1'b0;
        misses_seen = 0;
        first_ok    = -1;
        req_valid <= 1'b1;
        req_addr  <= fetch_q[0];
        while (sent < fetch_q.size() || exp_addr.size() > 0) begin
            @(posedge clk);
            if (rd_req) begin
                saw_req = 1'b1;
                check_that(exp_addr.size() > 0 && !exp_hit[0], "memory read for a predicted hit");
                check_that(rd_line_addr == exp_addr[0][31:icache_pkg::offset_w],
                    $sformatf("rd_line_addr %h for fetch %h", rd_line_addr, exp_addr[0]));
            end
            if (data_ok && exp_addr.size() == 0) begin
                check_that(1'b0, "data_ok with no fetch outstanding");
            end else if (data_ok) begin
                check_that(rdata == expected_word(exp_addr[0]),
                    $sformatf("fetch %h returned %h, expected %h",
                        exp_addr[0], rdata, expected_word(exp_addr[0])));
                if (exp_hit[0]) begin
                    check_that(cycle_cnt == acc_cyc[0] + 1, "hit data not one cycle after accept");
                end else begin
                    check_that(saw_req, "miss returned data without a memory read");
                end
                misses_seen += saw_req;
                if (first_ok < 0) begin
                    first_ok = cycle_cnt;
                end
                last_ok = cycle_cnt;
                saw_req = 1'b0;
                void'(exp_addr.pop_front());
                void'(exp_hit.pop_front());
                void'(acc_cyc.pop_front());
            end
            if (req_valid && addr_ok) begin
                exp_addr.push_back(req_addr);
                exp_hit.push_back(model_access(req_addr));
                acc_cyc.push_back(cycle_cnt);
                sent++;
                if (sent < fetch_q.size()) begin
                    req_addr <= fetch_q[sent];
                end else begin
                    req_valid <= 1'b0;
                end
            end
        end
        fetch_q.delete();
    endtask

    // negative counts skip the miss or span check
    task automatic run_test(input string name, input int exp_misses, input int exp_span);
        run_fetches();
        if (exp_misses >= 0) begin
            check_that(misses_seen == exp_misses,
                $sformatf("%s saw %0d misses, expected %0d", name, misses_seen, exp_misses));
        end
        if (exp_span >= 0) begin
            check_that(last_ok - first_ok == exp_span,
                $sformatf("%s data_ok spread over %0d cycles", name, last_ok - first_ok + 1));
        end
        if (errors == errors_at_start) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    task automatic cold_miss();
        fetch_q.push_back(make_addr('h1234, 5, 1));
        run_test("cold miss", 1, -1);
    endtask

    task automatic hit_after_fill();
        fetch_q.push_back(make_addr('h1234, 5, 0));
        fetch_q.push_back(make_addr('h1234, 5, 1));
        run_test("hit after fill", 0, -1);
    endtask

    task automatic streaming_hits();
        for (int i = 0; i < 4; i++) begin
            fetch_q.push_back(make_addr('h0777, 10 + i, 0));
        end
        run_fetches();
        for (int i = 0; i < 8; i++) begin
            fetch_q.push_back(make_addr('h0777, 10 + i / 2, i % 2));
        end
        run_test("streaming hits", 0, 7);
    endtask

    // touching the first tag leaves the second as victim
    task automatic lru_eviction();
        fetch_q.push_back(make_addr('h100, 20, 0));
        fetch_q.push_back(make_addr('h200, 20, 0));
        fetch_q.push_back(make_addr('h100, 20, 1));
        fetch_q.push_back(make_addr('h300, 20, 0));
        fetch_q.push_back(make_addr('h100, 20, 0));
        fetch_q.push_back(make_addr('h200, 20, 1));
        run_test("two ways and lru", 4, -1);
    endtask

    task automatic random_latency();
        for (int i = 0; i < max_fetches; i++) begin
            fetch_q.push_back(make_addr('h400 + $urandom_range(2), 40 + $urandom_range(1),
                $urandom_range(1)));
        end
        run_test("random latency", -1, -1);
    endtask

    initial begin
        void'($urandom(95));
        rst       <= 1'b1;
        req_valid <= 1'b0;
        req_addr  <= '0;
        for (int s = 0; s < icache_pkg::num_sets; s++) begin
            model_lru[s] = 1'b0;
            for (int w = 0; w < icache_pkg::num_ways; w++) begin
                model_valid[s][w] = 1'b0;
                model_tag[s][w]   = '0;
            end
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        // tag sweep holds addr_ok low
        @(posedge clk);
        while (!addr_ok) begin
            @(posedge clk);
        end
        cold_miss();
        hit_after_fill();
        streaming_hits();
        lru_eviction();
        random_latency();
        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
            n_tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- icache.f
icache_pkg.sv
icache_sram.sv
icache_ctrl.sv
icache_top.sv
icache_mem_model.sv
icache_assert.sv
icache_tb.sv
